//--- sram_pager.f
src/sram_pager_pkg.sv
src/ecc_store.sv
src/free_page_fifo.sv
src/batch_timer.sv
src/port_occupancy.sv
src/page_ctrl_fsm.sv
src/sram_pager.sv
verification/sram_pager_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert -Wno-fatal --top-module sram_pager_tb \
    -f sram_pager.f 2>&1 && ./obj_dir/Vsram_pager_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1

//--- verification/sram_pager_tb.sv
module sram_pager_tb;
    import sram_pager_pkg::*;

    typedef enum logic [2:0] {OP_ALLOC, OP_FREE, OP_BOTH, OP_ECC, OP_IDLE, OP_FULL} op_e;

    // Port is the allocating port, port2 the releasing one.
    typedef struct packed {
        op_e         op;
        logic [3:0]  port;
        logic [3:0]  port2;
        logic [11:0] count;
    } step_t;

    localparam int STEP_COUNT = 9;
    localparam step_t STEPS [STEP_COUNT] = '{
        '{OP_ALLOC, 4'd0, 4'd0, 12'd3},   '{OP_IDLE, 4'd0, 4'd0, 12'd10},
        '{OP_ALLOC, 4'd1, 4'd0, 12'd520}, '{OP_FREE, 4'd0, 4'd1, 12'd10},
        '{OP_BOTH, 4'd2, 4'd1, 12'd5},    '{OP_FREE, 4'd0, 4'd1, 12'd505},
        '{OP_ECC, 4'd0, 4'd0, 12'd8},     '{OP_FULL, 4'd3, 4'd3, 12'd0},
        '{OP_IDLE, 4'd0, 4'd0, 12'd10}
    };

    logic          clk;
    logic          arst_n;
    alloc_req_t    alloc;
    logic          alloc_ok;
    logic [PAGE_W-1:0] null_ptr;
    release_req_t  release_req;
    ecc_wr_t       ecc_wr;
    logic [PAGE_W-1:0] ecc_rd_addr;
    logic [ECC_W-1:0]  ecc_rd_code;
    pager_status_t status;
    occ_level_e [PORT_COUNT-1:0] prefer;

    // Reference model.
    int          free_q[$];
    int          held[PORT_COUNT][$];
    logic [ECC_W-1:0] ecc_model [PAGE_COUNT];
    int          cyc = 0;
    int          last_wr = -100;
    int          last_rd = -100;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr = 32'hbf8ee5af;
    bit          ready_ok;

    sram_pager sram_pager_inst (
        .clk(clk), .arst_n(arst_n), .alloc(alloc), .alloc_ok(alloc_ok), .null_ptr(null_ptr),
        .release_req(release_req), .ecc_wr(ecc_wr), .ecc_rd_addr(ecc_rd_addr),
        .ecc_rd_code(ecc_rd_code), .status(status), .prefer(prefer)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ====================
    // Helpers.
    // ====================
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int expected_level(int pages);
        if (pages == 0) return int'(LVL_EMPTY);
        if (pages < LVL_LOW_MAX) return int'(LVL_LOW);
        if (pages < LVL_MID_MAX) return int'(LVL_MID);
        return int'(LVL_HIGH);
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // Next falling edge with the activity flags checked.
    task automatic tick();
        @(negedge clk);
        check_val("status.writing", status.writing, int'(cyc - last_wr < BATCH_LEN));
        check_val("status.reading", status.reading, int'(cyc - last_rd < BATCH_LEN));
    endtask

    task automatic cycle(bit do_alloc, int a_port, bit do_rel, int r_port);
        bit exp_ok;
        bit has_rel;
        tick();
        exp_ok  = do_alloc && free_q.size() != 0;
        has_rel = do_rel && held[r_port].size() != 0 && free_q.size() != PAGE_COUNT;
        alloc = '{en: do_alloc, port: PORT_W'(a_port)};
        release_req = '{en: has_rel, port: PORT_W'(r_port),
                        addr: has_rel ? PAGE_W'(held[r_port][0]) : '0};
        #10;
        check_val("alloc_ok", alloc_ok, exp_ok);
        if (exp_ok) begin
            check_val("null_ptr", null_ptr, free_q[0]);
            held[a_port].push_back(free_q.pop_front());
            last_wr = cyc + 1;
        end
        if (has_rel) begin
            free_q.push_back(held[r_port].pop_front());
            last_rd = cyc + 1;
        end
    endtask

    // Two cycles after the last grant, so prefer has caught up.
    task automatic settle();
        tick();
        alloc = '0;
        release_req = '0;
        tick();
        check_val("status.ready", status.ready, 1);
        check_val("status.free_space", status.free_space, free_q.size());
        check_val("status.full", status.full, int'(free_q.size() == 0));
        for (int p = 0; p < PORT_COUNT; p++) begin
            check_val($sformatf("prefer[%0d]", p), prefer[p], expected_level(held[p].size()));
        end
    endtask

    task automatic run_step(step_t s);
        logic [PAGE_W-1:0] addr;
        logic [ECC_W-1:0]  code;
        logic [PAGE_W-1:0] ecc_addrs[$];
        case (s.op)
            OP_ALLOC: repeat (s.count) cycle(1, s.port, 0, 0);
            OP_FREE:  repeat (s.count) cycle(0, 0, 1, s.port2);
            OP_BOTH:  repeat (s.count) cycle(1, s.port, 1, s.port2);
            OP_IDLE:  repeat (s.count) tick();
            OP_ECC: begin
                // All writes first, so each read sees the whole RAM.
                repeat (s.count) begin
                    tick();
                    addr = PAGE_W'(rand_bits(PAGE_W));
                    code = ECC_W'(rand_bits(ECC_W));
                    ecc_wr = '{en: 1'b1, addr: addr, code: code};
                    ecc_model[addr] = code;
                    ecc_addrs.push_back(addr);
                end
                tick();
                ecc_wr.en = 1'b0;
                ecc_rd_addr = ecc_addrs[0];
                // Code lags the address by one cycle.
                for (int i = 1; i <= ecc_addrs.size(); i++) begin
                    tick();
                    if (i < ecc_addrs.size()) begin
                        ecc_rd_addr = ecc_addrs[i];
                    end
                    #10;
                    check_val("ecc_rd_code", ecc_rd_code, ecc_model[ecc_addrs[i - 1]]);
                end
            end
            default: begin
                while (free_q.size() != 0) cycle(1, s.port, 0, 0);
                settle();
                // Refused while full.
                cycle(1, s.port, 0, 0);
                settle();
                cycle(0, 0, 1, s.port2);
                settle();
                cycle(1, s.port, 0, 0);
            end
        endcase
        settle();
    endtask

    // ====================
    // Main sequence.
    // ====================
    initial begin
        int step_err;
        arst_n = 1'b0;
        alloc = '0;
        release_req = '0;
        ecc_wr = '0;
        ecc_rd_addr = '0;
        ready_ok = 1'b0;
        for (int i = 0; i < PAGE_COUNT; i++) free_q.push_back(i);
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        for (int n = 0; n < 2200 && !ready_ok; n++) begin
            @(negedge clk);
            ready_ok = status.ready;
        end
        if (!ready_ok) begin
            $display("Timed out after 2200 cycles waiting for ready after the reset sweep");
            $display("TEST FAILED");
            $finish;
        end else begin
            settle();
            $display("sweep: %0d errors", errors);
            for (int i = 0; i < STEP_COUNT; i++) begin
                step_err = errors;
                run_step(STEPS[i]);
                $display("step %0d %s: %0d errors", i, STEPS[i].op.name(), errors - step_err);
            end
            $display("%0d tests, %0d checks, %0d errors", STEP_COUNT + 1, checks, errors);
            if (errors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

//--- src/sram_pager.sv
module sram_pager (
    input  logic                              clk,
    input  logic                              arst_n,
    input  sram_pager_pkg::alloc_req_t        alloc,
    output logic                              alloc_ok,
    output logic [sram_pager_pkg::PAGE_W-1:0] null_ptr,
    input  sram_pager_pkg::release_req_t      release_req,
    input  sram_pager_pkg::ecc_wr_t           ecc_wr,
    input  logic [sram_pager_pkg::PAGE_W-1:0] ecc_rd_addr,
    output logic [sram_pager_pkg::ECC_W-1:0]  ecc_rd_code,
    output sram_pager_pkg::pager_status_t     status,
    output sram_pager_pkg::occ_level_e [sram_pager_pkg::PORT_COUNT-1:0] prefer
);
    import sram_pager_pkg::*;

    logic              alloc_go;
    logic              release_go;
    logic              init_push;
    logic [PAGE_W-1:0] init_addr;
    pager_state_e      state;
    logic [PAGE_W:0]   free_count;
    logic              wr_active;
    logic              rd_active;

    // ====================
    // Control and free list.
    // ====================
    page_ctrl_fsm ctrl_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .alloc_en   (alloc.en),
        .release_en (release_req.en),
        .free_count (free_count),
        .alloc_go   (alloc_go),
        .release_go (release_go),
        .init_push  (init_push),
        .init_addr  (init_addr),
        .state      (state)
    );

    free_page_fifo fifo_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .init_push  (init_push),
        .init_addr  (init_addr),
        .pop        (alloc_go),
        .push       (release_go),
        .push_addr  (release_req.addr),
        .head_addr  (null_ptr),
        .free_count (free_count)
    );

    assign alloc_ok = alloc_go;

    port_occupancy occ_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .inc      (alloc_go),
        .inc_port (alloc.port),
        .dec      (release_go),
        .dec_port (release_req.port),
        .prefer   (prefer)
    );

    ecc_store ecc_inst (
        .clk     (clk),
        .wr      (ecc_wr),
        .rd_addr (ecc_rd_addr),
        .rd_code (ecc_rd_code)
    );

    // ====================
    // Activity windows.
    // ====================
    batch_timer wr_timer (
        .clk    (clk),
        .arst_n (arst_n),
        .hit    (alloc_go),
        .active (wr_active)
    );

    batch_timer rd_timer (
        .clk    (clk),
        .arst_n (arst_n),
        .hit    (release_go),
        .active (rd_active)
    );

    assign status = '{
        ready:      (state != ST_INIT),
        writing:    wr_active,
        reading:    rd_active,
        full:       (state == ST_FULL),
        free_space: free_count
    };

endmodule

//--- src/page_ctrl_fsm.sv
module page_ctrl_fsm (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              alloc_en,
    input  logic                              release_en,
    input  logic [sram_pager_pkg::PAGE_W:0]   free_count,
    output logic                              alloc_go,
    output logic                              release_go,
    output logic                              init_push,
    output logic [sram_pager_pkg::PAGE_W-1:0] init_addr,
    output sram_pager_pkg::pager_state_e      state
);
    import sram_pager_pkg::*;

    pager_state_e    state_next;
    logic [PAGE_W:0] count_next;

    // ====================
    // Grants.
    // ====================
    assign init_push  = (state == ST_INIT);
    assign alloc_go   = (state == ST_RUN) && alloc_en && (free_count != '0);
    assign release_go = (state != ST_INIT) && release_en && (free_count != PAGE_COUNT);

    // Free count after this edge, so the full state tracks free_space.
    assign count_next = free_count + release_go - alloc_go;

    // ====================
    // State.
    // ====================
    always_comb begin
        state_next = state;
        case (state)
            ST_INIT: begin
                if (init_addr == PAGE_W'(PAGE_COUNT - 1)) begin
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                if (count_next == '0) begin
                    state_next = ST_FULL;
                end
            end
            ST_FULL: begin
                if (count_next != '0) begin
                    state_next = ST_RUN;
                end
            end
            default: state_next = ST_INIT;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_INIT;
            init_addr <= '0;
        end else begin
            state <= state_next;
            if (init_push) begin
                init_addr <= init_addr + 1'b1;
            end
        end
    end

endmodule

//--- src/port_occupancy.sv
module port_occupancy (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              inc,
    input  logic [sram_pager_pkg::PORT_W-1:0] inc_port,
    input  logic                              dec,
    input  logic [sram_pager_pkg::PORT_W-1:0] dec_port,
    output sram_pager_pkg::occ_level_e [sram_pager_pkg::PORT_COUNT-1:0] prefer
);
    import sram_pager_pkg::*;

    function automatic occ_level_e level_of(input logic [PAGE_W:0] pages);
        if (pages == '0) begin
            return LVL_EMPTY;
        end else if (pages < LVL_LOW_MAX) begin
            return LVL_LOW;
        end else if (pages < LVL_MID_MAX) begin
            return LVL_MID;
        end
        return LVL_HIGH;
    endfunction

    for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
        logic            up;
        logic            down;
        logic [PAGE_W:0] count;

        assign up   = inc && (inc_port == PORT_W'(p));
        assign down = dec && (dec_port == PORT_W'(p));

        // Up and down together on one port cancel.
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                count <= '0;
            end else if (up && !down) begin
                count <= count + 1'b1;
            end else if (down && !up) begin
                count <= count - 1'b1;
            end
        end

        // Level trails the counter by one cycle.
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                prefer[p] <= LVL_EMPTY;
            end else begin
                prefer[p] <= level_of(count);
            end
        end
    end

endmodule

//--- src/batch_timer.sv
module batch_timer (
    input  logic clk,
    input  logic arst_n,
    input  logic hit,
    output logic active
);
    import sram_pager_pkg::*;

    localparam int CNT_W = $clog2(BATCH_LEN);

    logic [CNT_W-1:0] idle_cnt;

    // Each hit restarts the window.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            idle_cnt <= '0;
        end else if (hit) begin
            active   <= 1'b1;
            idle_cnt <= '0;
        end else if (active) begin
            if (idle_cnt == CNT_W'(BATCH_LEN - 1)) begin
                active <= 1'b0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

endmodule

//--- src/free_page_fifo.sv
module free_page_fifo (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              init_push,
    input  logic [sram_pager_pkg::PAGE_W-1:0] init_addr,
    input  logic                              pop,
    input  logic                              push,
    input  logic [sram_pager_pkg::PAGE_W-1:0] push_addr,
    output logic [sram_pager_pkg::PAGE_W-1:0] head_addr,
    output logic [sram_pager_pkg::PAGE_W:0]   free_count
);
    import sram_pager_pkg::*;

    logic [PAGE_W-1:0] mem [PAGE_COUNT];
    logic [PAGE_W-1:0] head_ptr;
    logic [PAGE_W-1:0] tail_ptr;
    logic              wr_en;
    logic [PAGE_W-1:0] wr_data;

    // Sweep and release never overlap.
    assign wr_en   = init_push | push;
    assign wr_data = init_push ? init_addr : push_addr;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[tail_ptr] <= wr_data;
        end
    end

    assign head_addr = mem[head_ptr];

    // Pointers wrap at PAGE_COUNT by width.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_ptr   <= '0;
            tail_ptr   <= '0;
            free_count <= '0;
        end else begin
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (wr_en) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   free_count <= free_count + 1'b1;
                2'b01:   free_count <= free_count - 1'b1;
                default: free_count <= free_count;
            endcase
        end
    end

endmodule

//--- src/ecc_store.sv
module ecc_store (
    input  logic                              clk,
    input  sram_pager_pkg::ecc_wr_t           wr,
    input  logic [sram_pager_pkg::PAGE_W-1:0] rd_addr,
    output logic [sram_pager_pkg::ECC_W-1:0]  rd_code
);
    import sram_pager_pkg::*;

    // One code per page.
    logic [ECC_W-1:0] mem [PAGE_COUNT];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.code;
        end
    end

    // Registered read, old data on a same-address write.
    always_ff @(posedge clk) begin
        rd_code <= mem[rd_addr];
    end

endmodule

//--- src/sram_pager_pkg.sv
package sram_pager_pkg;

    // ====================
    // Sizes.
    // ====================
    localparam int PAGE_COUNT  = 2048;
    localparam int PAGE_W      = 11;
    localparam int PORT_COUNT  = 16;
    localparam int PORT_W      = 4;
    localparam int ECC_W       = 8;
    localparam int BATCH_LEN   = 8;

    // Occupancy thresholds in pages.
    localparam int LVL_LOW_MAX = 512;
    localparam int LVL_MID_MAX = 1536;

    // ====================
    // Types.
    // ====================
    typedef enum logic [1:0] {
        ST_INIT,
        ST_RUN,
        ST_FULL
    } pager_state_e;

    typedef enum logic [1:0] {
        LVL_EMPTY,
        LVL_LOW,
        LVL_MID,
        LVL_HIGH
    } occ_level_e;

    typedef struct packed {
        logic              en;
        logic [PORT_W-1:0] port;
    } alloc_req_t;

    typedef struct packed {
        logic              en;
        logic [PORT_W-1:0] port;
        logic [PAGE_W-1:0] addr;
    } release_req_t;

    typedef struct packed {
        logic              en;
        logic [PAGE_W-1:0] addr;
        logic [ECC_W-1:0]  code;
    } ecc_wr_t;

    // free_space runs 0 to PAGE_COUNT, hence one bit wider than a page address.
    typedef struct packed {
        logic            ready;
        logic            writing;
        logic            reading;
        logic            full;
        logic [PAGE_W:0] free_space;
    } pager_status_t;

endpackage
